// File: verilog/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t;
    typedef logic [7:0]  byte_t;

    // byte engine commands, CMD_START doubles as repeated start
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } byte_cmd_e;

    localparam logic [3:0] DEV_TYPE = 4'b1010; // 24cxx device type

    // apb offsets
    localparam logic [3:0] REG_ADDR   = 4'h0;
    localparam logic [3:0] REG_WDATA  = 4'h4;
    localparam logic [3:0] REG_CTRL   = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

    localparam int CTRL_GO       = 0;
    localparam int CTRL_READ     = 1;
    localparam int STAT_BUSY     = 0;
    localparam int STAT_NACK     = 1;
    localparam int STAT_RDATA_LO = 8; // read byte in 15:8

endpackage

`default_nettype wire

// File: verilog/byte_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_cmd_if;
    import eeprom_pkg::*;

    byte_cmd_e cmd;
    logic      valid;
    byte_t     wdata;
    logic      busy;
    logic      done;  // one cycle, busy falls with it
    byte_t     rdata;
    logic      nack;  // write commands only

    modport seq (output cmd, valid, wdata, input busy, done, rdata, nack);
    modport eng (input cmd, valid, wdata, output busy, done, rdata, nack);

endinterface

`default_nettype wire

// File: verilog/i2c_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine #(
    parameter int CLK_DIV = 8
) (
    input  logic       CLK,
    input  logic       RESET,
    byte_cmd_if.eng    bc,
    output logic       scl,
    output logic       sda_oe,
    input  logic       sda_in
);
    import eeprom_pkg::*;

    localparam int CW = $clog2(CLK_DIV);
    localparam logic [CW-1:0] HALF_END = CW'(CLK_DIV - 1);
    localparam logic [CW-1:0] HALF_MID = CW'(CLK_DIV / 2);

    typedef enum logic [1:0] {PH_IDLE, PH_LOW, PH_HIGH} phase_e;

    phase_e          phase;
    logic [CW-1:0]   cnt;     // position within the scl half period
    logic [3:0]      bit_cnt;
    byte_cmd_e       cmd_q;
    byte_t           shreg;
    logic            done_q;
    logic            nack_q;
    logic            is_mid;
    logic            is_end;
    logic            last_bit;

    assign is_mid = (cnt == HALF_MID);
    assign is_end = (cnt == HALF_END);
    // start and stop take one scl period, bytes take nine
    assign last_bit = (cmd_q == CMD_START || cmd_q == CMD_STOP) ? (bit_cnt == 4'd0)
                                                               : (bit_cnt == 4'd8);

    assign bc.busy  = (phase != PH_IDLE);
    assign bc.done  = done_q;
    assign bc.rdata = shreg;
    assign bc.nack  = nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase   <= PH_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            done_q  <= 1'b0;
            nack_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (phase)
                PH_IDLE:
                    if (bc.valid)
                    begin
                        cmd_q   <= bc.cmd;
                        shreg   <= bc.wdata;
                        nack_q  <= 1'b0;
                        bit_cnt <= '0;
                        cnt     <= '0;
                        scl     <= 1'b0;
                        phase   <= PH_LOW;
                    end
                PH_LOW:
                begin
                    cnt <= is_end ? '0 : cnt + 1'b1;
                    if (is_mid)
                    begin
                        case (cmd_q)
                            CMD_START: sda_oe <= 1'b0; // release before the high half
                            CMD_STOP:  sda_oe <= 1'b1;
                            CMD_WRITE:
                                if (bit_cnt < 4'd8)
                                begin
                                    sda_oe <= ~shreg[7]; // msb first
                                    shreg  <= {shreg[6:0], 1'b0};
                                end
                                else
                                    sda_oe <= 1'b0; // ack slot
                            default:   sda_oe <= 1'b0; // read data and final nack
                        endcase
                    end
                    if (is_end)
                    begin
                        scl   <= 1'b1;
                        phase <= PH_HIGH;
                    end
                end
                PH_HIGH:
                begin
                    cnt <= is_end ? '0 : cnt + 1'b1;
                    if (is_mid)
                    begin
                        case (cmd_q)
                            CMD_START: sda_oe <= 1'b1; // sda falls, scl high
                            CMD_STOP:  sda_oe <= 1'b0; // sda rises, scl high
                            CMD_WRITE:
                                if (bit_cnt == 4'd8)
                                    nack_q <= sda_in;
                            default:
                                if (bit_cnt < 4'd8)
                                    shreg <= {shreg[6:0], sda_in};
                        endcase
                    end
                    if (is_end)
                    begin
                        if (last_bit)
                        begin
                            done_q <= 1'b1;
                            phase  <= PH_IDLE;
                            if (cmd_q != CMD_STOP)
                                scl <= 1'b0; // bus stays owned between bytes
                        end
                        else
                        begin
                            scl     <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                            phase   <= PH_LOW;
                        end
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    start,
    input  logic                    rd_not_wr,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::byte_t       wdata,
    output logic                    busy,
    output logic                    nack,
    output eeprom_pkg::byte_t       rdata,
    byte_cmd_if.seq                 bc
);
    import eeprom_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_e;

    state_e       state;
    logic [2:0]   step;
    logic [2:0]   stop_step;
    logic         rd_q;
    eeprom_addr_t addr_q;
    byte_t        wdata_q;
    byte_t        ctrl_w;
    byte_t        ctrl_r;
    byte_cmd_e    cmd;
    byte_t        cmd_data;

    assign ctrl_w = {DEV_TYPE, addr_q[10:8], 1'b0};
    assign ctrl_r = {DEV_TYPE, addr_q[10:8], 1'b1};
    assign stop_step = rd_q ? 3'd6 : 3'd4;

    // command list, the write path ends at step 4
    always_comb
    begin
        cmd      = CMD_STOP;
        cmd_data = '0;
        case (step)
            3'd0: cmd = CMD_START;
            3'd1:
            begin
                cmd      = CMD_WRITE;
                cmd_data = ctrl_w;
            end
            3'd2:
            begin
                cmd      = CMD_WRITE;
                cmd_data = addr_q[7:0];
            end
            3'd3:
            begin
                cmd      = rd_q ? CMD_START : CMD_WRITE; // repeated start for reads
                cmd_data = wdata_q;
            end
            3'd4:
            begin
                cmd      = rd_q ? CMD_WRITE : CMD_STOP;
                cmd_data = ctrl_r;
            end
            3'd5: cmd = CMD_READ;
            default: cmd = CMD_STOP;
        endcase
    end

    assign bc.cmd   = cmd;
    assign bc.wdata = cmd_data;
    assign bc.valid = (state == S_ISSUE) && !bc.busy;
    assign busy     = (state != S_IDLE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= S_IDLE;
            step  <= '0;
            rd_q  <= 1'b0;
            nack  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (start)
                    begin
                        rd_q  <= rd_not_wr;
                        step  <= '0;
                        nack  <= 1'b0;
                        state <= S_ISSUE;
                    end
                S_ISSUE:
                    if (!bc.busy)
                        state <= S_WAIT;
                S_WAIT:
                    if (bc.done)
                    begin
                        if (cmd == CMD_STOP)
                            state <= S_IDLE;
                        else
                        begin
                            if (cmd == CMD_WRITE && bc.nack)
                            begin
                                nack <= 1'b1;
                                step <= stop_step; // abandon the rest
                            end
                            else
                                step <= step + 1'b1;
                            state <= S_ISSUE;
                        end
                    end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && start)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == S_WAIT && bc.done && cmd == CMD_READ)
            rdata <= bc.rdata;
    end

endmodule

`default_nettype wire

// File: verilog/apb_eeprom_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_eeprom_regs (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [3:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pslverr,
    output logic                     start,
    output logic                     rd_not_wr,
    output eeprom_pkg::eeprom_addr_t addr,
    output eeprom_pkg::byte_t        wdata,
    input  logic                     busy,
    input  logic                     nack,
    input  eeprom_pkg::byte_t        rdata
);
    import eeprom_pkg::*;

    logic        wr_acc;
    logic        wr_ok;
    logic [31:0] status;

    assign wr_acc  = psel && penable && pwrite;
    assign wr_ok   = wr_acc && !busy;
    assign pslverr = wr_acc && busy; // refused, registers untouched

    // start pulse lasts the access phase only
    assign start     = wr_ok && (paddr == REG_CTRL) && pwdata[CTRL_GO];
    assign rd_not_wr = pwdata[CTRL_READ];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            addr  <= '0;
            wdata <= '0;
        end
        else if (wr_ok)
        begin
            if (paddr == REG_ADDR)
                addr <= pwdata[10:0];
            if (paddr == REG_WDATA)
                wdata <= pwdata[7:0];
        end
    end

    always_comb
    begin
        status                        = '0;
        status[STAT_BUSY]             = busy;
        status[STAT_NACK]             = nack;
        status[STAT_RDATA_LO +: 8]    = rdata;
    end

    always_comb
    begin
        case (paddr)
            REG_ADDR:   prdata = {21'b0, addr};
            REG_WDATA:  prdata = {24'b0, wdata};
            REG_STATUS: prdata = status;
            default:    prdata = '0; // ctrl reads back zero
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 8
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_oe, // high pulls sda low
    input  logic        sda_in
);
    import eeprom_pkg::*;

    logic         start;
    logic         rd_not_wr;
    eeprom_addr_t addr;
    byte_t        wdata;
    logic         busy;
    logic         nack;
    byte_t        rdata;

    byte_cmd_if bc ();

    apb_eeprom_regs u_regs (
        .CLK       (CLK),
        .RESET     (RESET),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .start     (start),
        .rd_not_wr (rd_not_wr),
        .addr      (addr),
        .wdata     (wdata),
        .busy      (busy),
        .nack      (nack),
        .rdata     (rdata)
    );

    eeprom_sequencer u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .start     (start),
        .rd_not_wr (rd_not_wr),
        .addr      (addr),
        .wdata     (wdata),
        .busy      (busy),
        .nack      (nack),
        .rdata     (rdata),
        .bc        (bc.seq)
    );

    i2c_byte_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .CLK    (CLK),
        .RESET  (RESET),
        .bc     (bc.eng),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic CLK,
    output logic RESET
);
    localparam time HALF_PERIOD = 10ns; // 20 ns clock

    initial
    begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    initial
    begin
        RESET = 1'b1;
        repeat (4) @(posedge CLK);
        #2;
        RESET = 1'b0;
    end

endmodule

`default_nettype wire

// File: test/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic present,
    output logic sda_pull  // high pulls sda low
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_SEND} mstate_e;

    byte_t        mem [0:2047];
    mstate_e      mstate  = M_IDLE;
    mstate_e      next_st = M_IDLE;
    int           bit_n   = 0;     // scl rising edges within the byte
    byte_t        sh      = '0;
    logic [2:0]   blk     = '0;
    eeprom_addr_t ptr     = '0;
    byte_t        wbyte   = '0;
    logic         pending = 1'b0;  // data byte is written at stop
    logic         scl_q   = 1'b1;
    logic         sda_q   = 1'b1;

    initial
    begin
        sda_pull = 1'b0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff; // erased part
    end

    // called on the falling edge after the 8th bit
    task automatic take_byte();
        logic ack;
        ack     = 1'b1;
        next_st = M_IDLE;
        case (mstate)
            M_CTRL:
                if (sh[7:4] == DEV_TYPE)
                begin
                    blk     = sh[3:1];
                    next_st = sh[0] ? M_SEND : M_ADDR;
                end
                else
                    ack = 1'b0;
            M_ADDR:
            begin
                ptr     = {blk, sh};
                next_st = M_DATA;
            end
            M_DATA:
            begin
                wbyte   = sh;
                pending = 1'b1;
            end
            default: ack = 1'b0;
        endcase
        if (!(ack && present))
            next_st = M_IDLE;
        sda_pull = ack && present;
    endtask

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            mstate   = M_CTRL; // start, repeated start too
            bit_n    = 0;
            pending  = 1'b0;
            sda_pull = 1'b0;
        end
        else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            if (pending)
                mem[ptr] = wbyte;
            pending = 1'b0;
            mstate  = M_IDLE;
        end
        else if (scl_q === 1'b0 && scl === 1'b1 && mstate != M_IDLE)
        begin
            bit_n = bit_n + 1;
            if (mstate != M_SEND && bit_n <= 8)
                sh = {sh[6:0], sda};
        end
        else if (scl_q === 1'b1 && scl === 1'b0 && mstate == M_SEND)
        begin
            if (bit_n == 9)
                mstate = M_IDLE; // one byte per read
            else if (bit_n == 8)
                sda_pull = 1'b0; // master answers here
            else
            begin
                sh       = {sh[6:0], 1'b0};
                sda_pull = ~sh[7];
            end
        end
        else if (scl_q === 1'b1 && scl === 1'b0 && mstate != M_IDLE)
        begin
            if (bit_n == 8)
                take_byte();
            else if (bit_n == 9)
            begin
                bit_n    = 0;
                mstate   = next_st;
                sh       = mem[ptr];
                sda_pull = (mstate == M_SEND) ? ~sh[7] : 1'b0; // msb goes out early
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

// File: test/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int POLL_LIMIT  = 400;
    localparam int RESET_LIMIT = 20;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WRITE_BUSY} op_e;

    typedef struct {
        string        name;
        op_e          op;
        eeprom_addr_t addr;
        byte_t        data;
        logic         rnd;      // data from the xorshift stream
        logic         present;
        logic         exp_nack;
    } entry_t;

    logic        CLK;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        scl;
    logic        sda_oe;
    logic        sda_pull;
    logic        sda;
    logic        present;

    entry_t      entries[$];
    byte_t       shadow [0:2047];
    logic [31:0] rng;

    assign sda = ~(sda_oe | sda_pull); // wired-and bus

    tb_clock_gen u_clk (
        .CLK   (CLK),
        .RESET (RESET)
    );

    eeprom_model u_eeprom (
        .scl      (scl),
        .sda      (sda),
        .present  (present),
        .sda_pull (sda_pull)
    );

    eeprom_ctrl_top #(
        .CLK_DIV (4)
    ) dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected)
        begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("error %s expected %b actual %b", name, expected, actual);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // setup phase, then access phase, sampled at the falling edge
    task automatic write_reg(input logic [3:0] a, input logic [31:0] d, output logic err);
        @(posedge CLK);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = d;
        @(posedge CLK);
        #2;
        penable = 1'b1;
        @(negedge CLK);
        err = pslverr;
        @(posedge CLK);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] a, output logic [31:0] d);
        @(posedge CLK);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = a;
        @(posedge CLK);
        #2;
        penable = 1'b1;
        @(negedge CLK);
        d = prdata;
        @(posedge CLK);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle(input string name, output logic [31:0] status);
        int polls;
        polls = 0;
        read_reg(REG_STATUS, status);
        while (status[STAT_BUSY] !== 1'b0 && polls < POLL_LIMIT)
        begin
            read_reg(REG_STATUS, status);
            polls++;
        end
        if (status[STAT_BUSY] !== 1'b0)
        begin
            $display("%s: transfer still busy after %0d status reads", name, POLL_LIMIT);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    endtask

    task automatic add_entry(input string name, input op_e op, input eeprom_addr_t addr,
                             input byte_t data, input logic rnd, input logic pres,
                             input logic exp_nack);
        entry_t e;
        e.name     = name;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.rnd      = rnd;
        e.present  = pres;
        e.exp_nack = exp_nack;
        entries.push_back(e);
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] status;
        logic [31:0] rd;
        logic [31:0] ctrl;
        logic        err;
        byte_t       data;
        data = e.data;
        if (e.rnd)
        begin
            rng  = xorshift32(rng);
            data = rng[7:0];
        end
        present = e.present;
        write_reg(REG_ADDR, {21'b0, e.addr}, err);
        compare_flag({e.name, " addr pslverr"}, 1'b0, err);
        if (e.op != OP_READ)
        begin
            write_reg(REG_WDATA, {24'b0, data}, err);
            compare_flag({e.name, " wdata pslverr"}, 1'b0, err);
        end
        ctrl            = '0;
        ctrl[CTRL_GO]   = 1'b1;
        ctrl[CTRL_READ] = (e.op == OP_READ);
        write_reg(REG_CTRL, ctrl, err);
        compare_flag({e.name, " go pslverr"}, 1'b0, err);
        if (e.op == OP_WRITE_BUSY)
        begin
            write_reg(REG_WDATA, {24'b0, ~data}, err); // lands mid transfer
            compare_flag({e.name, " busy pslverr"}, 1'b1, err);
            read_reg(REG_WDATA, rd);
            compare_byte({e.name, " wdata kept"}, data, rd[7:0]);
        end
        wait_idle(e.name, status);
        compare_flag({e.name, " nack"}, e.exp_nack, status[STAT_NACK]);
        compare_flag({e.name, " sda_oe"}, 1'b0, sda_oe);
        compare_flag({e.name, " scl"}, 1'b1, scl);
        if (!e.exp_nack)
        begin
            if (e.op == OP_READ)
                compare_byte({e.name, " rdata"}, shadow[e.addr], status[STAT_RDATA_LO +: 8]);
            else
                shadow[e.addr] = data;
        end
    endtask

    initial
    begin
        logic [31:0] status;
        int          n;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        present = 1'b1;
        rng     = 32'hfb7;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hff;

        add_entry("wr_a",         OP_WRITE,      11'h012, 8'h5a, 1'b0, 1'b1, 1'b0);
        add_entry("rd_a",         OP_READ,       11'h012, 8'h00, 1'b0, 1'b1, 1'b0);
        add_entry("wr_blk0",      OP_WRITE,      11'h0a5, 8'h11, 1'b0, 1'b1, 1'b0);
        add_entry("wr_blk3",      OP_WRITE,      11'h3a5, 8'h33, 1'b0, 1'b1, 1'b0);
        add_entry("wr_blk7",      OP_WRITE,      11'h7a5, 8'h77, 1'b0, 1'b1, 1'b0);
        add_entry("rd_blk0",      OP_READ,       11'h0a5, 8'h00, 1'b0, 1'b1, 1'b0);
        add_entry("rd_blk3",      OP_READ,       11'h3a5, 8'h00, 1'b0, 1'b1, 1'b0);
        add_entry("rd_blk7",      OP_READ,       11'h7a5, 8'h00, 1'b0, 1'b1, 1'b0);
        add_entry("rd_blank",     OP_READ,       11'h444, 8'h00, 1'b0, 1'b1, 1'b0);
        add_entry("wr_absent",    OP_WRITE,      11'h012, 8'h00, 1'b1, 1'b0, 1'b1);
        add_entry("rd_absent",    OP_READ,       11'h3a5, 8'h00, 1'b0, 1'b0, 1'b1);
        add_entry("rd_a_again",   OP_READ,       11'h012, 8'h00, 1'b0, 1'b1, 1'b0);
        add_entry("wr_busy",      OP_WRITE_BUSY, 11'h6c3, 8'hc3, 1'b0, 1'b1, 1'b0);
        add_entry("rd_busy",      OP_READ,       11'h6c3, 8'h00, 1'b0, 1'b1, 1'b0);
        add_entry("wr_top",       OP_WRITE,      11'h7ff, 8'h00, 1'b1, 1'b1, 1'b0);
        add_entry("rd_top",       OP_READ,       11'h7ff, 8'h00, 1'b0, 1'b1, 1'b0);

        n = 0;
        while (RESET !== 1'b0 && n < RESET_LIMIT)
        begin
            @(posedge CLK);
            n++;
        end
        if (RESET !== 1'b0)
        begin
            $display("reset was never released");
            $display("Test failed");
            $fatal(1, "timeout");
        end

        read_reg(REG_STATUS, status);
        compare_flag("reset busy", 1'b0, status[STAT_BUSY]);
        compare_flag("reset nack", 1'b0, status[STAT_NACK]);
        compare_flag("reset scl", 1'b1, scl);
        compare_flag("reset sda_oe", 1'b0, sda_oe);

        for (int i = 0; i < entries.size(); i++)
            run_entry(entries[i]);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/eeprom_pkg.sv
verilog/byte_cmd_if.sv
verilog/i2c_byte_engine.sv
verilog/eeprom_sequencer.sv
verilog/apb_eeprom_regs.sv
verilog/eeprom_ctrl_top.sv
test/tb_clock_gen.sv
test/eeprom_model.sv
test/tb_eeprom_ctrl.sv

// File: Makefile
TOP = tb_eeprom_ctrl
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
